//--- design/spu_isa_pkg.sv
package spu_isa_pkg;

  // instruction word layout, bit 31 is the msb
  localparam int OPC_W      = 8;
  localparam int OPC_MSB    = 31;
  localparam int REG_ADDR_W = 7;
  localparam int IMM_W      = 10;
  localparam int RT_LSB     = 17;
  localparam int RA_LSB     = 10;
  localparam int RB_LSB     = 3;  // imm10 sits on bits 9..0 and overlaps rb

  typedef enum logic [OPC_W-1:0] {
    OP_NOP   = 8'h00,
    OP_LNOP  = 8'h01,
    OP_ADD   = 8'h10,
    OP_AND   = 8'h11,
    OP_SHLI  = 8'h12,
    OP_FMUL  = 8'h13,
    OP_LQD   = 8'h20,
    OP_STQD  = 8'h21,
    OP_SHUFB = 8'h22,
    OP_BR    = 8'h23
  } opcode_e;

  typedef enum logic {
    PIPE_EVEN = 1'b0,  // arithmetic
    PIPE_ODD  = 1'b1   // load/store, permute, branch
  } pipe_e;

  typedef enum logic [2:0] {
    UNIT_NONE = 3'd0,
    UNIT_SFX  = 3'd1,  // simple fixed point
    UNIT_FP   = 3'd2,
    UNIT_LS   = 3'd3,
    UNIT_PERM = 3'd4,
    UNIT_BR   = 3'd5
  } unit_e;

  typedef struct packed {
    opcode_e               opcode;
    pipe_e                 pipe;
    unit_e                 unit;
    logic [3:0]            latency;
    logic                  reg_wr;
    logic                  reads_ra;
    logic                  reads_rb;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] ra;
    logic [REG_ADDR_W-1:0] rb;
    logic [IMM_W-1:0]      imm10;
  } decoded_t;

endpackage

//--- design/issue_pkg.sv
package issue_pkg;

  import spu_isa_pkg::*;

  typedef struct packed {
    logic [31:0] instr1;  // first in program order
    logic [31:0] instr2;
  } instr_pair_t;

  // a slot carries the decoded fields unchanged
  typedef decoded_t issue_slot_t;

  typedef struct packed {
    issue_slot_t even_slot;
    issue_slot_t odd_slot;
  } issue_bundle_t;

  localparam issue_slot_t EVEN_FILLER = '{
    opcode: OP_NOP, pipe: PIPE_EVEN, unit: UNIT_NONE,
    latency: 4'd0, reg_wr: 1'b0, reads_ra: 1'b0, reads_rb: 1'b0,
    rt: '0, ra: '0, rb: '0, imm10: '0
  };

  localparam issue_slot_t ODD_FILLER = '{
    opcode: OP_LNOP, pipe: PIPE_ODD, unit: UNIT_NONE,
    latency: 4'd0, reg_wr: 1'b0, reads_ra: 1'b0, reads_rb: 1'b0,
    rt: '0, ra: '0, rb: '0, imm10: '0
  };

endpackage

//--- design/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);

  logic load;

  // accept when empty or when the held item leaves this cycle
  assign in_ready = !out_valid || out_ready;
  assign load     = in_valid && in_ready;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      out_data <= in_data;
    end
  end

endmodule

//--- design/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder
  import spu_isa_pkg::*;
(
  input  logic [31:0] instr,
  output decoded_t    dec
);

  logic [OPC_W-1:0] opc_raw;
  logic             imm_form;

  assign opc_raw = instr[OPC_MSB -: OPC_W];

  always_comb begin
    dec      = '0;  // nop in the even pipe, no unit
    imm_form = 1'b0;
    dec.ra   = instr[RA_LSB +: REG_ADDR_W];
    dec.rb   = instr[RB_LSB +: REG_ADDR_W];
    case (opc_raw)
      OP_LNOP: begin
        dec.opcode = OP_LNOP;
        dec.pipe   = PIPE_ODD;
      end
      OP_ADD, OP_AND, OP_FMUL: begin
        dec.opcode   = opcode_e'(opc_raw);
        dec.unit     = (opc_raw == OP_FMUL) ? UNIT_FP : UNIT_SFX;
        dec.latency  = (opc_raw == OP_FMUL) ? 4'd6 : 4'd2;
        dec.reg_wr   = 1'b1;
        dec.reads_ra = 1'b1;
        dec.reads_rb = 1'b1;
      end
      OP_SHLI: begin
        dec.opcode   = OP_SHLI;
        dec.unit     = UNIT_SFX;
        dec.latency  = 4'd4;
        dec.reg_wr   = 1'b1;
        dec.reads_ra = 1'b1;
        imm_form     = 1'b1;
      end
      OP_LQD, OP_STQD: begin
        dec.opcode   = opcode_e'(opc_raw);
        dec.pipe     = PIPE_ODD;
        dec.unit     = UNIT_LS;
        dec.latency  = (opc_raw == OP_LQD) ? 4'd6 : 4'd0;  // store has no result
        dec.reg_wr   = (opc_raw == OP_LQD);
        dec.reads_ra = 1'b1;
        imm_form     = 1'b1;
      end
      OP_SHUFB: begin
        dec.opcode   = OP_SHUFB;
        dec.pipe     = PIPE_ODD;
        dec.unit     = UNIT_PERM;
        dec.latency  = 4'd4;
        dec.reg_wr   = 1'b1;
        dec.reads_ra = 1'b1;
        dec.reads_rb = 1'b1;
      end
      OP_BR: begin
        dec.opcode  = OP_BR;
        dec.pipe    = PIPE_ODD;
        dec.unit    = UNIT_BR;
        dec.latency = 4'd1;
        imm_form    = 1'b1;
      end
      default: ;  // unknown opcodes stay a plain nop
    endcase
    if (dec.reg_wr) begin
      dec.rt = instr[RT_LSB +: REG_ADDR_W];
    end
    if (imm_form) begin
      dec.imm10 = instr[IMM_W-1:0];
    end
  end

endmodule

//--- design/dual_issue_ctrl.sv
`timescale 1ns/1ps

module dual_issue_ctrl
  import spu_isa_pkg::*;
  import issue_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  logic          pair_valid,
  input  decoded_t      dec1,
  input  decoded_t      dec2,
  output logic          pair_ready,
  output logic          bundle_valid,
  output issue_bundle_t bundle,
  input  logic          bundle_ready
);

  logic        second_pending;  // first half of a split pair already issued
  logic        same_pipe;
  logic        ra_hit;
  logic        rb_hit;
  logic        data_dep;
  logic        split;
  logic        bundle_xfer;
  issue_slot_t single;

  assign same_pipe = (dec1.pipe == dec2.pipe);
  assign ra_hit    = dec2.reads_ra && (dec2.ra == dec1.rt);
  assign rb_hit    = dec2.reads_rb && (dec2.rb == dec1.rt);
  assign data_dep  = dec1.reg_wr && (ra_hit || rb_hit);
  assign split     = same_pipe || data_dep;

  assign bundle_valid = pair_valid;
  assign bundle_xfer  = bundle_valid && bundle_ready;

  // the pair leaves only with its last bundle
  assign pair_ready = bundle_ready && (!split || second_pending);

  assign single = second_pending ? dec2 : dec1;

  always_comb begin
    bundle.even_slot = EVEN_FILLER;
    bundle.odd_slot  = ODD_FILLER;
    if (!split) begin
      // pipes differ here, so one of each
      if (dec1.pipe == PIPE_EVEN) begin
        bundle.even_slot = dec1;
        bundle.odd_slot  = dec2;
      end else begin
        bundle.even_slot = dec2;
        bundle.odd_slot  = dec1;
      end
    end else if (single.pipe == PIPE_EVEN) begin
      bundle.even_slot = single;
    end else begin
      bundle.odd_slot = single;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      second_pending <= 1'b0;
    end else if (bundle_xfer && split) begin
      second_pending <= !second_pending;  // toggles once per half
    end
  end

endmodule

//--- design/issue_stage_top.sv
`timescale 1ns/1ps

module issue_stage_top
  import spu_isa_pkg::*;
  import issue_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  logic          pair_valid,
  input  instr_pair_t   pair,
  output logic          pair_ready,
  output logic          issue_valid,
  output issue_bundle_t bundle,
  input  logic          issue_ready
);

  instr_pair_t   pair_q;
  logic          pair_q_valid;
  logic          pair_q_ready;
  decoded_t      dec1;
  decoded_t      dec2;
  issue_bundle_t ctrl_bundle;
  logic          ctrl_valid;
  logic          ctrl_ready;

  pipe_reg #(.payload_t(instr_pair_t)) pair_reg (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (pair_valid),
    .in_data   (pair),
    .in_ready  (pair_ready),
    .out_valid (pair_q_valid),
    .out_data  (pair_q),
    .out_ready (pair_q_ready)
  );

  instr_decoder dec1_i (.instr(pair_q.instr1), .dec(dec1));
  instr_decoder dec2_i (.instr(pair_q.instr2), .dec(dec2));

  dual_issue_ctrl ctrl (
    .clk          (clk),
    .rst          (rst),
    .pair_valid   (pair_q_valid),
    .dec1         (dec1),
    .dec2         (dec2),
    .pair_ready   (pair_q_ready),
    .bundle_valid (ctrl_valid),
    .bundle       (ctrl_bundle),
    .bundle_ready (ctrl_ready)
  );

  pipe_reg #(.payload_t(issue_bundle_t)) bundle_reg (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (ctrl_valid),
    .in_data   (ctrl_bundle),
    .in_ready  (ctrl_ready),
    .out_valid (issue_valid),
    .out_data  (bundle),
    .out_ready (issue_ready)
  );

endmodule

//--- tests/issue_stage_chk.sv
`timescale 1ns/1ps

module issue_stage_chk
  import spu_isa_pkg::*;
  import issue_pkg::*;
(
  input logic          clk,
  input logic          rst,
  input logic          issue_valid,
  input logic          issue_ready,
  input issue_bundle_t bundle
);

  held_bundle_stable: assert property (@(posedge clk) disable iff (rst)
    issue_valid && !issue_ready |=> issue_valid && $stable(bundle))
    else $error("held bundle changed before it was taken");

  even_slot_opcode: assert property (@(posedge clk) disable iff (rst)
    issue_valid |-> bundle.even_slot.opcode inside {OP_NOP, OP_ADD, OP_AND, OP_SHLI, OP_FMUL})
    else $error("odd-pipe opcode in the even slot");

  odd_slot_opcode: assert property (@(posedge clk) disable iff (rst)
    issue_valid |-> bundle.odd_slot.opcode inside {OP_LNOP, OP_LQD, OP_STQD, OP_SHUFB, OP_BR})
    else $error("even-pipe opcode in the odd slot");

  // fillers never write a register
  even_filler_no_write: assert property (@(posedge clk) disable iff (rst)
    issue_valid && bundle.even_slot.opcode == OP_NOP |-> !bundle.even_slot.reg_wr)
    else $error("nop in the even slot writes a register");

  odd_filler_no_write: assert property (@(posedge clk) disable iff (rst)
    issue_valid && bundle.odd_slot.opcode == OP_LNOP |-> !bundle.odd_slot.reg_wr)
    else $error("lnop in the odd slot writes a register");

  quiet_after_reset: assert property (@(posedge clk) $fell(rst) |-> !issue_valid)
    else $error("issue_valid high right after reset");

endmodule

bind issue_stage_top issue_stage_chk chk (
  .clk         (clk),
  .rst         (rst),
  .issue_valid (issue_valid),
  .issue_ready (issue_ready),
  .bundle      (bundle)
);

//--- tests/issue_stage_tb.sv
`timescale 1ns/1ps

module issue_stage_tb
  import spu_isa_pkg::*;
  import issue_pkg::*;
();

  localparam int RESET_CYCLES   = 10;
  localparam int N_DIRECTED     = 9;
  localparam int N_RANDOM       = 500;
  localparam int TIMEOUT_CYCLES = (N_DIRECTED + N_RANDOM) * 4 + 200;
  localparam logic [7:0] OPC_POOL [11] = '{8'h00, 8'h01, 8'h10, 8'h11, 8'h12, 8'h13,
                                           8'h20, 8'h21, 8'h22, 8'h23, 8'hff};

  logic          clk;
  logic          rst;
  logic          pair_valid;
  instr_pair_t   pair;
  logic          pair_ready;
  logic          issue_valid;
  issue_bundle_t bundle;
  logic          issue_ready;
  logic          random_ready;  // random back-pressure on the sink side
  issue_bundle_t exp_q[$];

  issue_stage_top uut (.*);

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check(input string name, input logic [127:0] actual,
                       input logic [127:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("Mismatch %s: got %h, expected %h", name, actual, expected));
    end
  endtask

  function automatic logic [31:0] encode_rr(input opcode_e op, input logic [6:0] rt,
                                            input logic [6:0] ra, input logic [6:0] rb);
    return {op, rt, ra, rb, 3'b000};
  endfunction

  function automatic logic [31:0] encode_ri(input opcode_e op, input logic [6:0] rt,
                                            input logic [6:0] ra, input logic [9:0] imm);
    return {op, rt, ra, imm};
  endfunction

  function automatic logic [31:0] random_word();
    logic [31:0] r;
    int          idx;
    r   = $urandom();
    idx = $urandom() % 11;
    // small register numbers so that dependencies show up often
    return {OPC_POOL[idx], 5'd0, r[1:0], 5'd0, r[3:2], 5'd0, r[5:4], r[8:6]};
  endfunction

  // flags are {writes rt, reads ra, reads rb}
  function automatic decoded_t table_row(input opcode_e op, input pipe_e pipe, input unit_e unit,
                                         input logic [3:0] lat, input logic [2:0] flags);
    decoded_t d;
    d = '0;
    d.opcode  = op;
    d.pipe    = pipe;
    d.unit    = unit;
    d.latency = lat;
    {d.reg_wr, d.reads_ra, d.reads_rb} = flags;
    return d;
  endfunction

  function automatic decoded_t ref_decode(input logic [31:0] w);
    decoded_t d;
    case (w[31:24])
      8'h01:   d = table_row(OP_LNOP, PIPE_ODD, UNIT_NONE, 4'd0, 3'b000);
      8'h10:   d = table_row(OP_ADD, PIPE_EVEN, UNIT_SFX, 4'd2, 3'b111);
      8'h11:   d = table_row(OP_AND, PIPE_EVEN, UNIT_SFX, 4'd2, 3'b111);
      8'h12:   d = table_row(OP_SHLI, PIPE_EVEN, UNIT_SFX, 4'd4, 3'b110);
      8'h13:   d = table_row(OP_FMUL, PIPE_EVEN, UNIT_FP, 4'd6, 3'b111);
      8'h20:   d = table_row(OP_LQD, PIPE_ODD, UNIT_LS, 4'd6, 3'b110);
      8'h21:   d = table_row(OP_STQD, PIPE_ODD, UNIT_LS, 4'd0, 3'b010);
      8'h22:   d = table_row(OP_SHUFB, PIPE_ODD, UNIT_PERM, 4'd4, 3'b111);
      8'h23:   d = table_row(OP_BR, PIPE_ODD, UNIT_BR, 4'd1, 3'b000);
      default: d = table_row(OP_NOP, PIPE_EVEN, UNIT_NONE, 4'd0, 3'b000);
    endcase
    d.ra = w[16:10];
    d.rb = w[9:3];
    if (d.reg_wr) begin
      d.rt = w[23:17];
    end
    if (d.opcode inside {OP_SHLI, OP_LQD, OP_STQD, OP_BR}) begin
      d.imm10 = w[9:0];
    end
    return d;
  endfunction

  // one instruction in its own slot, filler in the other
  function automatic issue_bundle_t place(input decoded_t d);
    issue_bundle_t b;
    b.even_slot = table_row(OP_NOP, PIPE_EVEN, UNIT_NONE, 4'd0, 3'b000);
    b.odd_slot  = table_row(OP_LNOP, PIPE_ODD, UNIT_NONE, 4'd0, 3'b000);
    if (d.pipe == PIPE_EVEN) begin
      b.even_slot = d;
    end else begin
      b.odd_slot = d;
    end
    return b;
  endfunction

  function automatic int ref_issue(input instr_pair_t p, output issue_bundle_t b1,
                                   output issue_bundle_t b2);
    decoded_t d1;
    decoded_t d2;
    logic     dep;
    d1  = ref_decode(p.instr1);
    d2  = ref_decode(p.instr2);
    dep = d1.reg_wr && ((d2.reads_ra && d2.ra == d1.rt) || (d2.reads_rb && d2.rb == d1.rt));
    b1  = place(d1);
    b2  = place(d2);
    if (d1.pipe == d2.pipe || dep) begin
      return 2;
    end
    if (d2.pipe == PIPE_EVEN) begin
      b1.even_slot = d2;
    end else begin
      b1.odd_slot = d2;
    end
    return 1;
  endfunction

  task automatic send_pair(input instr_pair_t p, input logic gaps);
    issue_bundle_t b1;
    issue_bundle_t b2;
    logic          accepted;
    int            n_bundles;
    if (gaps && ($urandom() % 4) == 0) begin
      @(posedge clk);
      #1;
    end
    pair_valid = 1'b1;
    pair       = p;
    accepted   = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = pair_ready;
      @(posedge clk);
      #1;
    end
    pair_valid = 1'b0;
    n_bundles  = ref_issue(p, b1, b2);
    exp_q.push_back(b1);
    if (n_bundles == 2) begin
      exp_q.push_back(b2);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    forever begin
      @(posedge clk);
      #1;
      issue_ready = random_ready ? (($urandom() % 4) != 0) : 1'b1;
    end
  end

  // scoreboard, sampled at the falling edge ahead of the transfer
  initial begin
    issue_bundle_t expected;
    forever begin
      @(negedge clk);
      if (!rst && issue_valid && issue_ready) begin
        if (exp_q.size() == 0) begin
          abort_run("a bundle was issued while no bundle was expected");
        end else begin
          expected = exp_q.pop_front();
          check("bundle", 128'(bundle), 128'(expected));
        end
      end
    end
  end

  initial begin
    repeat (RESET_CYCLES + TIMEOUT_CYCLES) @(posedge clk);
    abort_run("timeout while bundles were still missing");
  end

  initial begin
    void'($urandom(32'hf057_4f5c));
    rst          = 1'b1;
    pair_valid   = 1'b0;
    pair         = '0;
    issue_ready  = 1'b1;
    random_ready = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (5) begin
      @(negedge clk);
      check("issue_valid", 128'(issue_valid), 128'd0);
    end
    @(posedge clk);
    #1;
    send_pair({encode_rr(OP_ADD, 7'd5, 7'd1, 7'd2), encode_ri(OP_LQD, 7'd6, 7'd3, 10'd8)}, 1'b0);
    send_pair({encode_rr(OP_SHUFB, 7'd7, 7'd1, 7'd2), encode_rr(OP_FMUL, 7'd8, 7'd3, 7'd4)}, 1'b0);
    send_pair({encode_rr(OP_ADD, 7'd9, 7'd1, 7'd2), encode_rr(OP_FMUL, 7'd3, 7'd4, 7'd5)}, 1'b0);
    send_pair({encode_ri(OP_LQD, 7'd9, 7'd1, 10'd4), encode_rr(OP_SHUFB, 7'd3, 7'd4, 7'd5)}, 1'b0);
    send_pair({encode_rr(OP_ADD, 7'd10, 7'd1, 7'd2), encode_ri(OP_LQD, 7'd11, 7'd10, 10'd0)}, 1'b0);
    send_pair({encode_ri(OP_LQD, 7'd12, 7'd1, 10'd0), encode_rr(OP_AND, 7'd13, 7'd1, 7'd12)}, 1'b0);
    send_pair({encode_ri(OP_STQD, 7'd14, 7'd1, 10'd0), encode_rr(OP_ADD, 7'd15, 7'd14, 7'd14)},
              1'b0);
    send_pair({encode_ri(OP_BR, 7'd9, 7'd0, 10'd5), encode_rr(OP_FMUL, 7'd2, 7'd9, 7'd9)}, 1'b0);
    send_pair({encode_ri(OP_LQD, 7'd20, 7'd1, 10'd0), encode_ri(OP_SHLI, 7'd21, 7'd1, 10'd160)},
              1'b0);
    random_ready = 1'b1;
    repeat (N_RANDOM) begin
      send_pair({random_word(), random_word()}, 1'b1);
    end
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    random_ready = 1'b0;
    // extra bundles after the last expected one trip the scoreboard here
    repeat (20) @(posedge clk);
    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- sources.f
design/spu_isa_pkg.sv
design/issue_pkg.sv
design/pipe_reg.sv
design/instr_decoder.sv
design/dual_issue_ctrl.sv
design/issue_stage_top.sv
tests/issue_stage_chk.sv
tests/issue_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the issue stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module issue_stage_tb \
  -Mdir "$BUILD_DIR" -o issue_stage_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$BUILD_DIR/issue_stage_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
